// ==== verilog/memory_consts.svh ====
// MB20 core memory sizing constants
// Word, bus address and array address widths plus quadword size
`ifndef MEMORY_CONSTS_SVH
`define MEMORY_CONSTS_SVH

// Width of one core memory word, 36 data bits
`define WORD_BITS 36

// Bus word address width as seen on the storage bus
`define SBUS_ADDR_BITS 24

// Installed array size is 256K words
`define MEM_ADDR_BITS 18

// Words per quadword, also the width of the request mask
`define QUAD_WORDS 4

`endif

// ==== verilog/sbusPkg.sv ====
// Storage bus side types
// Bus word address with flat and quadword views, plus request mask
`include "memory_consts.svh"

package sbusPkg;

  // Quadword view of a bus address
  typedef struct packed {
    logic [`SBUS_ADDR_BITS-$clog2(`QUAD_WORDS)-1:0] quadBase; // Quadword base address
    logic [$clog2(`QUAD_WORDS)-1:0]                 wordOffset; // First word in quadword
  } sbusQuadAddr_t;

  // One bus address word, decoded two ways
  typedef union packed {
    logic [`SBUS_ADDR_BITS-1:0] flat; // Whole word address, for existence check
    sbusQuadAddr_t              quad; // Base and offset, for the sequencers
  } sbusAddr_u;

  // Words requested, bit 0 is the first word of the walk
  typedef logic [`QUAD_WORDS-1:0] rqMask_t;

endpackage

// ==== verilog/memPkg.sv ====
// Core memory side types
// Word, array address and quadword split of the array address
`include "memory_consts.svh"

package memPkg;

  typedef logic [`WORD_BITS-1:0] memWord_t; // One core word
  typedef logic [`MEM_ADDR_BITS-1:0] memAddr_t; // Address into installed array

  // Quadword base within installed memory
  typedef logic [`MEM_ADDR_BITS-$clog2(`QUAD_WORDS)-1:0] memQuadBase_t;

  typedef logic [$clog2(`QUAD_WORDS)-1:0] wordOffset_t; // Word within quadword

endpackage

// ==== verilog/sbusRequestDecode.sv ====
// Storage bus request decode
// Splits the bus address, rejects nonexistent memory, issues phase load strobes
`include "memory_consts.svh"

module sbusRequestDecode (
  input  logic                 SBUS,
  input  logic                 reset,
  input  logic                 startA,
  input  logic                 startB,
  input  sbusPkg::sbusAddr_u   adr,
  input  sbusPkg::rqMask_t     rq,
  output logic                 loadA,
  output logic                 loadB,
  output memPkg::memQuadBase_t quadBase,
  output memPkg::wordOffset_t  wordOffset,
  output sbusPkg::rqMask_t     mask
);

  logic exists; // Address falls inside installed memory

  // Any bit above the installed size means no module answers there
  assign exists = (adr.flat[`SBUS_ADDR_BITS-1:`MEM_ADDR_BITS] == '0);

  // Nonexistent address is simply ignored, like a missing MB20 module
  assign loadA = startA && exists;
  assign loadB = startB && exists;

  // Both sequencers see the same request fields, only the strobe differs
  assign quadBase   = memPkg::memQuadBase_t'(adr.quad.quadBase); // Upper bits checked above
  assign wordOffset = adr.quad.wordOffset;
  assign mask       = rq; // Bit 0 is the first word served

  // Requester issues at most one phase start per cycle
  assert property (@(posedge SBUS) disable iff (reset) !(startA && startB))
    else $error("Error %0t startA and startB high together", $time);

endmodule

// ==== verilog/memPhaseSeq.sv ====
// One MB20 phase engine
// Latches a quadword request and walks its mask one word per cycle
module memPhaseSeq (
  input  logic                 SBUS,
  input  logic                 reset,
  input  logic                 load,
  input  memPkg::memQuadBase_t quadBase,
  input  memPkg::wordOffset_t  wordOffset,
  input  sbusPkg::rqMask_t     mask,
  output logic                 ack,
  output logic                 valid,
  output memPkg::memAddr_t     readAddr
);

  memPkg::memQuadBase_t base;   // Quadword base being served
  memPkg::wordOffset_t  offset; // Running word offset, wraps mod 4
  sbusPkg::rqMask_t     toAck;  // Words still to serve, head at bit 0

  // Control state
  always_ff @(posedge SBUS) begin
    if (reset) begin
      offset <= '0;
      toAck  <= '0;
    end else if (load) begin // New request, also replaces a walk in progress
      offset <= wordOffset;
      toAck  <= mask;
    end else if (toAck != '0) begin
      offset <= memPkg::wordOffset_t'(offset + 1'b1); // Wraps within the quadword
      toAck  <= toAck >> 1; // Next word moves to the head
    end
  end

  // Base only matters while a walk is live
  always_ff @(posedge SBUS) begin
    if (load) begin
      base <= quadBase;
    end
  end

  // Acknowledge and data valid are the same level here
  assign ack   = toAck[0];
  assign valid = toAck[0];

  assign readAddr = {base, offset}; // Word currently presented

  // A valid must trace back to a load within the last four edges
  assert property (@(posedge SBUS) disable iff (reset)
    $rose(valid) |-> ($past(load, 1) || $past(load, 2) || $past(load, 3) || $past(load, 4)))
    else $error("Error %0t valid rose with no recent load", $time);

endmodule

// ==== verilog/memStore.sv ====
// MB20 core array
// Maintenance write port and one asynchronous read port per phase
`include "memory_consts.svh"

module memStore (
  input  logic             SBUS,
  input  logic             writeEn,
  input  memPkg::memAddr_t writeAddr,
  input  memPkg::memWord_t writeData,
  input  memPkg::memAddr_t readAddrA,
  input  memPkg::memAddr_t readAddrB,
  output memPkg::memWord_t readDataA,
  output memPkg::memWord_t readDataB
);

  // 256K words of core
  memPkg::memWord_t core [0:(1 << `MEM_ADDR_BITS)-1];

  // Load path, used to fill the array before bus traffic
  always_ff @(posedge SBUS) begin
    if (writeEn) begin
      core[writeAddr] <= writeData;
    end
  end

  // Reads are combinational so data lines up with valid
  assign readDataA = core[readAddrA]; // Phase A word
  assign readDataB = core[readAddrB]; // Phase B word

endmodule

// ==== verilog/sbusDataDriver.sv ====
// Storage bus data driver
// Puts the valid phase's word and its parity on the shared data bus
module sbusDataDriver (
  input  logic             validA,
  input  logic             validB,
  input  memPkg::memWord_t readDataA,
  input  memPkg::memWord_t readDataB,
  output memPkg::memWord_t data,
  output logic             dataPar
);

  // Only one phase owns the bus in any cycle
  always_comb begin
    if (validA) begin
      data = readDataA;
    end else if (validB) begin
      data = readDataB;
    end else begin
      data = '0; // Idle bus reads as zero
    end
  end

  // XOR parity of the bus word goes low when idle
  assign dataPar = ^data;

  // Overlapping phases would collide on the shared bus
  assert final (!(validA === 1'b1 && validB === 1'b1))
    else $error("Error %0t validA and validB high together", $time);

endmodule

// ==== verilog/sbusMemory.sv ====
// MB20-style core memory on the storage bus
// Request decode, two phase engines, core array and bus data driver
module sbusMemory (
  input  logic               SBUS,
  input  logic               reset,
  input  logic               startA,
  input  logic               startB,
  input  sbusPkg::sbusAddr_u adr,
  input  sbusPkg::rqMask_t   rq,
  input  logic               writeEn,
  input  memPkg::memAddr_t   writeAddr,
  input  memPkg::memWord_t   writeData,
  output logic               ackA,
  output logic               validA,
  output logic               ackB,
  output logic               validB,
  output memPkg::memWord_t   data,
  output logic               dataPar
);

  logic                 loadA;      // Phase A takes the request
  logic                 loadB;      // Phase B takes the request
  memPkg::memQuadBase_t quadBase;
  memPkg::wordOffset_t  wordOffset;
  sbusPkg::rqMask_t     mask;
  memPkg::memAddr_t     readAddrA;
  memPkg::memAddr_t     readAddrB;
  memPkg::memWord_t     readDataA;
  memPkg::memWord_t     readDataB;

  sbusRequestDecode decode (
    .SBUS(SBUS), .reset(reset), .startA(startA), .startB(startB), .adr(adr), .rq(rq),
    .loadA(loadA), .loadB(loadB), .quadBase(quadBase), .wordOffset(wordOffset),
    .mask(mask)
  );

  memPhaseSeq phaseA (
    .SBUS(SBUS), .reset(reset), .load(loadA), .quadBase(quadBase),
    .wordOffset(wordOffset), .mask(mask), .ack(ackA), .valid(validA),
    .readAddr(readAddrA)
  );

  memPhaseSeq phaseB (
    .SBUS(SBUS), .reset(reset), .load(loadB), .quadBase(quadBase),
    .wordOffset(wordOffset), .mask(mask), .ack(ackB), .valid(validB),
    .readAddr(readAddrB)
  );

  memStore store (
    .SBUS(SBUS), .writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
    .readAddrA(readAddrA), .readAddrB(readAddrB),
    .readDataA(readDataA), .readDataB(readDataB)
  );

  sbusDataDriver driver (
    .validA(validA), .validB(validB), .readDataA(readDataA), .readDataB(readDataB),
    .data(data), .dataPar(dataPar)
  );

endmodule

// ==== verif/sbusMemory_tb.sv ====
// Testbench for the MB20-style storage bus memory
// Preloads a region, runs directed and random quadword reads, checks every cycle
`include "memory_consts.svh"

module sbusMemory_tb;

  localparam logic [`MEM_ADDR_BITS-1:0] REGION_BASE = 'h3FF00; // Top 256 words of core
  localparam logic [15:0] REGION_QUAD = 16'(REGION_BASE >> 2);
  localparam int REGION_WORDS = 256;
  localparam int ACK_WAIT_LIMIT = 8;  // Cycles allowed to collect a walk's acks
  localparam int WATCH_CYCLES = 8;    // Silence window for a nonexistent address
  localparam int RANDOM_REQUESTS = 24;

  // One expected bus cycle for a phase
  typedef struct packed {
    logic             valid;
    logic             par;
    memPkg::memWord_t word;
  } busStep_t;

  logic               SBUS;
  logic               reset;
  logic               startA;
  logic               startB;
  sbusPkg::sbusAddr_u adr;
  sbusPkg::rqMask_t   rq;
  logic               writeEn;
  memPkg::memAddr_t   writeAddr;
  memPkg::memWord_t   writeData;
  logic               ackA;
  logic               validA;
  logic               ackB;
  logic               validB;
  memPkg::memWord_t   data;
  logic               dataPar;

  memPkg::memWord_t shadow [0:(1 << `MEM_ADDR_BITS)-1]; // Mirror of the core array
  logic [31:0] lcgState = 33919;

  // Latched request per phase, step 4 means idle
  memPkg::memQuadBase_t baseA, baseB;
  memPkg::wordOffset_t  offA, offB;
  sbusPkg::rqMask_t     maskA, maskB;
  int stepNumA = 4;
  int stepNumB = 4;
  bit resetSeen = 0; // Outputs are defined once a reset edge has passed

  sbusMemory DUT (
    .SBUS(SBUS), .reset(reset), .startA(startA), .startB(startB), .adr(adr), .rq(rq),
    .writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
    .ackA(ackA), .validA(validA), .ackB(ackB), .validB(validB),
    .data(data), .dataPar(dataPar)
  );

  always #2 SBUS = ~SBUS; // Period 4

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic int countBits(input logic [3:0] m);
    int n;
    n = 0;
    for (int i = 0; i < 4; i++) begin
      n += m[i];
    end
    return n;
  endfunction

  function automatic logic [`SBUS_ADDR_BITS-1:0] makeAddr(input logic [15:0] quad,
                                                          input logic [1:0] off);
    return {{(`SBUS_ADDR_BITS-`MEM_ADDR_BITS){1'b0}}, quad, off};
  endfunction

  // Word k of a walk is memory[base, (offset + k) mod 4], present only if mask bit k is set
  function automatic busStep_t expectStep(input memPkg::memQuadBase_t base,
                                          input memPkg::wordOffset_t off,
                                          input sbusPkg::rqMask_t mask, input int k);
    busStep_t r;
    logic [1:0] wordSel;
    r = '0;
    if (k < 4 && mask[k]) begin
      wordSel = off + k[1:0]; // Wraps inside the quadword
      r.valid = 1'b1;
      r.word  = shadow[{base, wordSel}];
      r.par   = ^r.word;
    end
    return r;
  endfunction

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("Error %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // Model follows the bus rules at each rising edge
  always @(posedge SBUS) begin
    if (reset) begin
      resetSeen = 1;
      stepNumA = 4;
      stepNumB = 4;
    end else begin
      if (startA && adr.flat < (1 << `MEM_ADDR_BITS)) begin
        baseA = adr.flat[`MEM_ADDR_BITS-1:2];
        offA = adr.flat[1:0];
        maskA = rq;
        stepNumA = 0;
      end else if (stepNumA < 4) begin
        stepNumA++;
      end
      if (startB && adr.flat < (1 << `MEM_ADDR_BITS)) begin
        baseB = adr.flat[`MEM_ADDR_BITS-1:2];
        offB = adr.flat[1:0];
        maskB = rq;
        stepNumB = 0;
      end else if (stepNumB < 4) begin
        stepNumB++;
      end
    end
    if (writeEn) begin
      shadow[writeAddr] = writeData; // Same edge as the core write
    end
  end

  // Compare at the falling edge, half a cycle after outputs settle
  always @(negedge SBUS) begin : compare
    busStep_t stepA;
    busStep_t stepB;
    memPkg::memWord_t expWord;
    logic expPar;
    if (resetSeen) begin
      stepA = expectStep(baseA, offA, maskA, stepNumA);
      stepB = expectStep(baseB, offB, maskB, stepNumB);
      expWord = stepA.valid ? stepA.word : (stepB.valid ? stepB.word : '0); // Idle bus is zero
      expPar = stepA.valid ? stepA.par : (stepB.valid ? stepB.par : 1'b0);
      checkValue("ackA", ackA, stepA.valid);
      checkValue("validA", validA, stepA.valid);
      checkValue("ackB", ackB, stepB.valid);
      checkValue("validB", validB, stepB.valid);
      checkValue("data", data, expWord);
      checkValue("dataPar", dataPar, expPar);
    end
  end

  // One-cycle start strobe, returns at the falling edge of walk step 0
  task automatic issueRequest(input bit phaseB, input logic [`SBUS_ADDR_BITS-1:0] address,
                              input logic [3:0] req);
    @(negedge SBUS);
    adr.flat = address;
    rq = req;
    startA = !phaseB;
    startB = phaseB;
    @(negedge SBUS);
    startA = 1'b0;
    startB = 1'b0;
  endtask

  task automatic waitForAcks(input bit phaseB, input int want);
    int seen;
    int cycles;
    seen = 0;
    cycles = 0;
    while (seen < want) begin
      if (cycles == ACK_WAIT_LIMIT) begin
        stopOnError($sformatf("Timed out at %0t waiting for read acknowledges", $time));
      end else begin
        if (phaseB ? ackB : ackA) seen++;
        if (seen < want) begin
          @(negedge SBUS);
          cycles++;
        end
      end
    end
  endtask

  task automatic watchNoAck();
    for (int i = 0; i < WATCH_CYCLES; i++) begin
      if (ackA || ackB) begin
        stopOnError($sformatf("Acknowledge at %0t for a nonexistent address", $time));
      end else begin
        @(negedge SBUS);
      end
    end
  endtask

  task automatic preloadRegion();
    logic [31:0] hi;
    logic [31:0] lo;
    for (int i = 0; i < REGION_WORDS; i++) begin
      hi = nextRandom();
      lo = nextRandom();
      @(negedge SBUS);
      writeEn = 1'b1;
      writeAddr = REGION_BASE + `MEM_ADDR_BITS'(i);
      writeData = {hi[27:24], lo}; // 36-bit word from two draws
    end
    @(negedge SBUS);
    writeEn = 1'b0;
  endtask

  initial begin
    logic [15:0] quad;
    logic [1:0] off;
    logic [3:0] m;
    logic [31:0] r;
    int skip;
    bit phaseB;
    SBUS = 1'b0;
    reset = 1'b1;
    startA = 1'b0;
    startB = 1'b0;
    adr = '0;
    rq = '0;
    writeEn = 1'b0;
    writeAddr = '0;
    writeData = '0;
    repeat (5) @(negedge SBUS);
    reset = 1'b0;
    @(negedge SBUS);
    checkValue("ackA", ackA, 0); // Quiet bus straight after reset
    checkValue("validB", validB, 0);
    checkValue("data", data, 0);
    preloadRegion();

    // Full quadword on A in address order
    issueRequest(0, makeAddr(REGION_QUAD + 16'd1, 2'd0), 4'b1111);
    checkValue("ackA", ackA, 1); // First word one cycle after the start
    waitForAcks(0, 4);

    // Sparse mask on B starting at offset 3, wraps to offsets 0 and 2
    issueRequest(1, makeAddr(REGION_QUAD + 16'd5, 2'd3), 4'b1010);
    checkValue("ackB", ackB, 0);
    waitForAcks(1, 2);
    issueRequest(1, makeAddr(REGION_QUAD + 16'd9, 2'd2), 4'b1001);
    waitForAcks(1, 2);

    // Nonexistent memory stays silent
    issueRequest(0, 24'h040000, 4'b1111);
    watchNoAck();
    issueRequest(1, 24'hFFFFFC, 4'b0111);
    watchNoAck();

    for (int i = 0; i < RANDOM_REQUESTS; i++) begin
      phaseB = i[0]; // Alternate phases
      r = nextRandom();
      quad = REGION_QUAD + 16'(r[23:18]);
      off = r[13:12];
      m = (r[29:26] == 4'b0) ? 4'b0001 : r[29:26];
      if (r[31:30] == 2'b00) begin // Restart this walk early
        skip = r[8];
        issueRequest(phaseB, makeAddr(quad, off), m);
        repeat (skip) @(negedge SBUS);
        r = nextRandom();
        quad = REGION_QUAD + 16'(r[23:18]);
        off = r[13:12];
        m = (r[29:26] == 4'b0) ? 4'b1000 : r[29:26];
      end
      issueRequest(phaseB, makeAddr(quad, off), m);
      waitForAcks(phaseB, countBits(m));
    end

    repeat (4) @(negedge SBUS);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/sbusPkg.sv
verilog/memPkg.sv
verilog/sbusRequestDecode.sv
verilog/memPhaseSeq.sv
verilog/memStore.sv
verilog/sbusDataDriver.sv
verilog/sbusMemory.sv
verif/sbusMemory_tb.sv
